// ==== Makefile ====
SIM := obj_dir/Vtb_scan_doubler
SOURCES := $(shell cat flist.f)

.PHONY: all run clean

all: run

# rebuilt only when the file list or a source changes
$(SIM): flist.f $(SOURCES)
	verilator --binary --top-module tb_scan_doubler -f flist.f

# pass or fail is taken from the simulation output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf obj_dir

// ==== flist.f ====
hw/scan_doubler_pkg.sv
hw/line_capture.sv
hw/line_store.sv
hw/line_playback.sv
hw/scan_doubler.sv
verification/tb_scan_doubler.sv

// ==== hw/line_capture.sv ====
`timescale 1ns/1ns

module line_capture (
	input logic pixel_clk_in,
	input logic arst_n,
	input logic pix_en,
	input scan_doubler_pkg::rgb_t pixel,
	input logic hsync_in,
	input logic vsync_in,
	output logic wr_en,
	output logic wr_bank,
	output scan_doubler_pkg::pixel_addr_t wr_addr,
	output scan_doubler_pkg::rgb_t wr_pixel,
	output logic line_done,
	output scan_doubler_pkg::line_info_t line_info
);

	logic hsync_prev;
	logic line_end;
	logic hsync_rise;
	logic bank;
	logic sync_seen;
	logic line_vsync;
	logic room_left;
	scan_doubler_pkg::pixel_count_t wr_pos;
	scan_doubler_pkg::pixel_count_t sync_width;

	// a line ends on a sampled falling edge of hsync
	assign line_end = pix_en && hsync_prev && !hsync_in;
	assign hsync_rise = pix_en && !hsync_prev && hsync_in;

	assign room_left = wr_pos < scan_doubler_pkg::pixel_count_t'(scan_doubler_pkg::max_line_pixels);

	// the pixel that ends a line is the first pixel of the next one,
	// so it goes to address 0 of the other bank straight away
	assign wr_en = pix_en && (line_end || room_left);
	assign wr_bank = line_end ? !bank : bank;
	assign wr_addr = line_end ? '0 : scan_doubler_pkg::pixel_addr_t'(wr_pos);
	assign wr_pixel = pixel;

	always_ff @(posedge pixel_clk_in or negedge arst_n) begin
		if (!arst_n) begin
			hsync_prev <= 1'b1;
			wr_pos <= '0;
			bank <= 1'b0;
			sync_width <= '0;
			sync_seen <= 1'b0;
			line_vsync <= 1'b1;
			line_done <= 1'b0;
		end else begin
			line_done <= line_end;
			if (pix_en) begin
				hsync_prev <= hsync_in;
			end
			if (line_end) begin
				bank <= !bank;
				wr_pos <= scan_doubler_pkg::pixel_count_t'(1);
				sync_seen <= 1'b0;
				line_vsync <= vsync_in;
			end else if (pix_en) begin
				// past the end of the bank the count sticks and pixels are dropped
				if (room_left) begin
					wr_pos <= wr_pos + scan_doubler_pkg::pixel_count_t'(1);
				end
				if (hsync_rise && !sync_seen) begin
					sync_width <= wr_pos;
					sync_seen <= 1'b1;
				end
			end
		end
	end

	// a line whose sync never rose is treated as sync for its whole width
	always_ff @(posedge pixel_clk_in) begin
		if (line_end) begin
			line_info <= '{
				width: wr_pos,
				sync_width: sync_seen ? sync_width : wr_pos,
				vsync: line_vsync,
				bank: bank
			};
		end
	end

endmodule

// ==== hw/line_playback.sv ====
`timescale 1ns/1ns

module line_playback (
	input logic pixel_clk_in,
	input logic arst_n,
	input logic line_done,
	input scan_doubler_pkg::line_info_t line_info,
	input scan_doubler_pkg::rgb_t rd_pixel,
	output logic rd_bank,
	output scan_doubler_pkg::pixel_addr_t rd_addr,
	output scan_doubler_pkg::rgb_t rgb_out,
	output logic de_out,
	output logic hsync_out,
	output logic vsync_out
);

	scan_doubler_pkg::playback_state_t state;
	scan_doubler_pkg::line_info_t active;
	scan_doubler_pkg::line_info_t pending;
	scan_doubler_pkg::pixel_addr_t rd_cnt;
	logic pending_valid;
	logic new_line;
	logic last_pixel;

	// stage one lines up with the store output, stage two is the output register
	logic de_s1;
	logic hsync_s1;
	logic vsync_s1;

	// an empty line has nothing to play back
	assign new_line = line_done && (line_info.width != '0);

	assign last_pixel = (scan_doubler_pkg::pixel_count_t'(rd_cnt) +
		scan_doubler_pkg::pixel_count_t'(1)) == active.width;

	assign rd_bank = active.bank;
	assign rd_addr = rd_cnt;

	always_ff @(posedge pixel_clk_in or negedge arst_n) begin
		if (!arst_n) begin
			state <= scan_doubler_pkg::idle;
			active <= '0;
			rd_cnt <= '0;
			pending_valid <= 1'b0;
		end else begin
			case (state)
				scan_doubler_pkg::idle: begin
					if (new_line) begin
						active <= line_info;
						rd_cnt <= '0;
						state <= scan_doubler_pkg::first_pass;
					end
				end
				scan_doubler_pkg::first_pass: begin
					if (last_pixel) begin
						rd_cnt <= '0;
						state <= scan_doubler_pkg::second_pass;
					end else begin
						rd_cnt <= rd_cnt + scan_doubler_pkg::pixel_addr_t'(1);
					end
					if (new_line) begin
						pending_valid <= 1'b1;
					end
				end
				scan_doubler_pkg::second_pass: begin
					if (!last_pixel) begin
						rd_cnt <= rd_cnt + scan_doubler_pkg::pixel_addr_t'(1);
						if (new_line) begin
							pending_valid <= 1'b1;
						end
					end else begin
						rd_cnt <= '0;
						if (pending_valid) begin
							active <= pending;
							pending_valid <= new_line;
							state <= scan_doubler_pkg::first_pass;
						end else if (new_line) begin
							// a line finishing right now goes straight to playback
							active <= line_info;
							state <= scan_doubler_pkg::first_pass;
						end else begin
							state <= scan_doubler_pkg::idle;
						end
					end
				end
				default: begin
					state <= scan_doubler_pkg::idle;
				end
			endcase
		end
	end

	// only meaningful while pending_valid is set
	always_ff @(posedge pixel_clk_in) begin
		if (new_line && state != scan_doubler_pkg::idle) begin
			pending <= line_info;
		end
	end

	always_ff @(posedge pixel_clk_in or negedge arst_n) begin
		if (!arst_n) begin
			de_s1 <= 1'b0;
			hsync_s1 <= 1'b1;
			vsync_s1 <= 1'b1;
			de_out <= 1'b0;
			hsync_out <= 1'b1;
			vsync_out <= 1'b1;
			rgb_out <= '0;
		end else begin
			de_s1 <= state != scan_doubler_pkg::idle;
			hsync_s1 <= !(scan_doubler_pkg::pixel_count_t'(rd_cnt) < active.sync_width);
			vsync_s1 <= active.vsync;
			de_out <= de_s1;
			rgb_out <= de_s1 ? rd_pixel : '0;
			hsync_out <= de_s1 ? hsync_s1 : 1'b1;
			vsync_out <= de_s1 ? vsync_s1 : 1'b1;
		end
	end

endmodule

// ==== hw/line_store.sv ====
`timescale 1ns/1ns

module line_store (
	input logic pixel_clk_in,
	input logic wr_en,
	input logic wr_bank,
	input scan_doubler_pkg::pixel_addr_t wr_addr,
	input scan_doubler_pkg::rgb_t wr_pixel,
	input logic rd_bank,
	input scan_doubler_pkg::pixel_addr_t rd_addr,
	output scan_doubler_pkg::rgb_t rd_pixel
);

	// two banks side by side, the bank select is the top address bit
	scan_doubler_pkg::rgb_t mem [0:2*scan_doubler_pkg::max_line_pixels-1];

	logic [scan_doubler_pkg::line_addr_w:0] wr_index;
	logic [scan_doubler_pkg::line_addr_w:0] rd_index;

	assign wr_index = {wr_bank, wr_addr};
	assign rd_index = {rd_bank, rd_addr};

	always_ff @(posedge pixel_clk_in) begin
		if (wr_en) begin
			mem[wr_index] <= wr_pixel;
		end
	end

	// read data comes out one cycle after the address
	always_ff @(posedge pixel_clk_in) begin
		rd_pixel <= mem[rd_index];
	end

endmodule

// ==== hw/scan_doubler.sv ====
`timescale 1ns/1ns

module scan_doubler (
	input logic pixel_clk_in,
	input logic arst_n,
	input logic pix_en,
	input scan_doubler_pkg::rgb_t pixel,
	input logic hsync_in,
	input logic vsync_in,
	output scan_doubler_pkg::rgb_t rgb_out,
	output logic de_out,
	output logic hsync_out,
	output logic vsync_out
);

	logic wr_en;
	logic wr_bank;
	scan_doubler_pkg::pixel_addr_t wr_addr;
	scan_doubler_pkg::rgb_t wr_pixel;
	logic line_done;
	scan_doubler_pkg::line_info_t line_info;
	logic rd_bank;
	scan_doubler_pkg::pixel_addr_t rd_addr;
	scan_doubler_pkg::rgb_t rd_pixel;

	line_capture u_capture (
		.pixel_clk_in(pixel_clk_in),
		.arst_n(arst_n),
		.pix_en(pix_en),
		.pixel(pixel),
		.hsync_in(hsync_in),
		.vsync_in(vsync_in),
		.wr_en(wr_en),
		.wr_bank(wr_bank),
		.wr_addr(wr_addr),
		.wr_pixel(wr_pixel),
		.line_done(line_done),
		.line_info(line_info)
	);

	// capture fills one bank while playback reads the other
	line_store u_store (
		.pixel_clk_in(pixel_clk_in),
		.wr_en(wr_en),
		.wr_bank(wr_bank),
		.wr_addr(wr_addr),
		.wr_pixel(wr_pixel),
		.rd_bank(rd_bank),
		.rd_addr(rd_addr),
		.rd_pixel(rd_pixel)
	);

	line_playback u_playback (
		.pixel_clk_in(pixel_clk_in),
		.arst_n(arst_n),
		.line_done(line_done),
		.line_info(line_info),
		.rd_pixel(rd_pixel),
		.rd_bank(rd_bank),
		.rd_addr(rd_addr),
		.rgb_out(rgb_out),
		.de_out(de_out),
		.hsync_out(hsync_out),
		.vsync_out(vsync_out)
	);

endmodule

// ==== hw/scan_doubler_pkg.sv ====
package scan_doubler_pkg;

	// bits per colour component
	localparam int unsigned component_depth = 8;

	// pixels per bank of the line store
	localparam int unsigned max_line_pixels = 1024;

	// address width of one bank, log2 of max_line_pixels
	localparam int unsigned line_addr_w = 10;

	typedef logic [component_depth-1:0] component_t;

	// position of a pixel within a stored line
	typedef logic [line_addr_w-1:0] pixel_addr_t;

	// one bit wider than an address so a full line of max_line_pixels fits
	typedef logic [line_addr_w:0] pixel_count_t;

	typedef struct packed {
		component_t red;
		component_t green;
		component_t blue;
	} rgb_t;

	// descriptor handed from capture to playback for every finished line
	typedef struct packed {
		pixel_count_t width;
		pixel_count_t sync_width;
		logic vsync;
		logic bank;
	} line_info_t;

	typedef enum logic [1:0] {
		idle,
		first_pass,
		second_pass
	} playback_state_t;

endpackage

// ==== verification/tb_scan_doubler.sv ====
`timescale 1ns/1ns

module tb_scan_doubler;

	// one captured line as the comparison process expects to see it
	typedef struct packed {
		int unsigned id;
		int unsigned phase;
		int unsigned base;
		int unsigned width;
		int unsigned sync_width;
		logic vsync;
	} line_rec_t;

	typedef struct packed {
		scan_doubler_pkg::rgb_t pixel;
		logic hsync;
		logic vsync;
	} pixel_exp_t;

	logic pixel_clk_in = 1'b0;
	logic arst_n;
	logic pix_en;
	scan_doubler_pkg::rgb_t pixel;
	logic hsync_in;
	logic vsync_in;
	scan_doubler_pkg::rgb_t rgb_out;
	logic de_out;
	logic hsync_out;
	logic vsync_out;

	integer seed;
	scan_doubler_pkg::rgb_t line_pixels [0:8191];
	line_rec_t line_queue [$];
	line_rec_t open_line;
	logic open_valid;
	int unsigned store_top;
	int unsigned line_count;
	int unsigned prev_width;
	int unsigned total_width;
	int unsigned cur_phase;
	logic stream_done = 1'b0;
	int unsigned timeout_count;

	line_rec_t cur;
	pixel_exp_t exp_px;
	string idle_label;
	int unsigned rec_idx = 0;
	int unsigned out_idx = 0;
	int unsigned pass_no = 0;
	int unsigned de_count = 0;
	int unsigned quiet_cycles = 0;
	int unsigned pixel_count = 0;
	int unsigned error_count = 0;
	logic drain_checked = 1'b0;

	scan_doubler DUT (
		.pixel_clk_in(pixel_clk_in),
		.arst_n(arst_n),
		.pix_en(pix_en),
		.pixel(pixel),
		.hsync_in(hsync_in),
		.vsync_in(vsync_in),
		.rgb_out(rgb_out),
		.de_out(de_out),
		.hsync_out(hsync_out),
		.vsync_out(vsync_out)
	);

	always #4 pixel_clk_in = ~pixel_clk_in;

	function automatic string phase_name(input int unsigned id);
		case (id)
			0: return "short lines";
			1: return "random frame";
			2: return "varying widths";
			3: return "full line";
			4: return "overlong line";
			default: return "recovery line";
		endcase
	endfunction

	function automatic string pixel_label(input line_rec_t rec, input int unsigned pass,
		input int unsigned idx, input string sig);
		return $sformatf("%s line %0d pass %0d pixel %0d %s", phase_name(rec.phase), rec.id,
			pass, idx, sig);
	endfunction

	// each pass repeats the stored pixels, hsync is low on the first sync_width of them
	function automatic pixel_exp_t expected_output(input line_rec_t rec, input int unsigned idx);
		pixel_exp_t e;
		e.pixel = line_pixels[13'(rec.base + idx)];
		e.hsync = idx >= rec.sync_width;
		e.vsync = rec.vsync;
		return e;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s expected %0h actual %0h", name, expected, actual);
			error_count++;
		end
	endtask

	function automatic int unsigned random_below(input int unsigned n);
		logic [31:0] r;
		r = $random(seed);
		return r % n;
	endfunction

	function automatic scan_doubler_pkg::rgb_t random_pixel();
		logic [31:0] r;
		r = $random(seed);
		return r[23:0];
	endfunction

	task automatic idle_cycles(input int unsigned n);
		repeat (n) @(negedge pixel_clk_in);
	endtask

	// one sample with pix_en high, then one cycle with it low
	task automatic drive_sample(input scan_doubler_pkg::rgb_t px, input logic hs, input logic vs);
		@(negedge pixel_clk_in);
		pix_en = 1'b1;
		pixel = px;
		hsync_in = hs;
		vsync_in = vs;
		@(negedge pixel_clk_in);
		pix_en = 1'b0;
	endtask

	task automatic close_open_line();
		if (open_valid) begin
			line_queue.push_back(open_line);
			total_width += open_line.width;
			open_valid = 1'b0;
		end
	endtask

	task automatic send_line(input int unsigned width_in, input int unsigned sync_in,
		input logic vs);
		line_rec_t rec;
		scan_doubler_pkg::rgb_t px;
		int unsigned stored;
		int unsigned i;
		stored = (width_in > scan_doubler_pkg::max_line_pixels) ?
			scan_doubler_pkg::max_line_pixels : width_in;
		rec = '{id: line_count, phase: cur_phase, base: store_top, width: stored,
			sync_width: sync_in, vsync: vs};
		for (i = 0; i < width_in; i++) begin
			px = random_pixel();
			if (i < stored) begin
				line_pixels[13'(store_top + i)] = px;
			end
			drive_sample(px, i >= sync_in, vs);
			// the first sample of this line is what ends the previous one
			if (i == 0) begin
				close_open_line();
			end
		end
		open_line = rec;
		open_valid = 1'b1;
		store_top += stored;
		line_count++;
		// a short line is stretched so the line before it has played out twice by its end
		if (prev_width > width_in) begin
			idle_cycles(2 * (prev_width - width_in));
		end
		prev_width = stored;
	endtask

	task automatic end_stream();
		drive_sample(random_pixel(), 1'b0, 1'b1);
		close_open_line();
	endtask

	always @(posedge pixel_clk_in) begin
		if (arst_n) begin
			if (de_out) begin
				de_count++;
				quiet_cycles = 0;
				if (rec_idx >= $unsigned(line_queue.size())) begin
					$display("de_out is high while no captured line is waiting for playback");
					error_count++;
				end else begin
					cur = line_queue[rec_idx];
					exp_px = expected_output(cur, out_idx);
					check_value(pixel_label(cur, pass_no, out_idx, "rgb_out"),
						32'(exp_px.pixel), 32'(rgb_out));
					check_value(pixel_label(cur, pass_no, out_idx, "hsync_out"),
						32'(exp_px.hsync), 32'(hsync_out));
					check_value(pixel_label(cur, pass_no, out_idx, "vsync_out"),
						32'(exp_px.vsync), 32'(vsync_out));
					pixel_count++;
					if (out_idx + 1 < cur.width) begin
						out_idx++;
					end else begin
						out_idx = 0;
						if (pass_no == 0) begin
							pass_no = 1;
						end else begin
							pass_no = 0;
							rec_idx++;
						end
					end
				end
			end else begin
				// both passes run without a gap, so de_out may only drop after the second
				if (out_idx != 0 || pass_no != 0) begin
					$display("de_out dropped during pass %0d of line %0d", pass_no,
						line_queue[rec_idx].id);
					error_count++;
					out_idx = 0;
					pass_no = 0;
					rec_idx++;
				end
				idle_label = (line_queue.size() == 0) ? "after reset" : "idle";
				check_value({idle_label, " hsync_out"}, 32'd1, 32'(hsync_out));
				check_value({idle_label, " vsync_out"}, 32'd1, 32'(vsync_out));
				check_value({idle_label, " rgb_out"}, 32'd0, 32'(rgb_out));
				// once the stream has ended a long quiet stretch means playback is idle
				if (stream_done && !drain_checked) begin
					quiet_cycles++;
					if (quiet_cycles == 16) begin
						check_value("total de_out pixels", 2 * total_width, de_count);
						drain_checked = 1'b1;
					end
				end
			end
		end
	end

	initial begin
		int unsigned k;
		int unsigned w;
		int unsigned s;
		int unsigned limit;
		seed = 32'hf369;
		arst_n = 1'b0;
		pix_en = 1'b0;
		pixel = '0;
		hsync_in = 1'b1;
		vsync_in = 1'b1;
		open_valid = 1'b0;
		store_top = 0;
		line_count = 0;
		prev_width = 0;
		total_width = 0;
		cur_phase = 0;
		timeout_count = 0;
		repeat (3) @(negedge pixel_clk_in);
		arst_n = 1'b1;
		idle_cycles(20);

		for (k = 2; k <= 5; k++) begin
			send_line(k, 1, 1'b1);
		end

		cur_phase = 1;
		for (k = 0; k < 10; k++) begin
			w = 8 + random_below(64);
			s = 1 + random_below(w / 4 + 1);
			// vsync is low on lines 4 and 5, where one frame ends and the next begins
			send_line(w, s, !(k == 4 || k == 5));
		end

		cur_phase = 2;
		send_line(40, 5, 1'b1);
		send_line(7, 2, 1'b1);
		send_line(120, 30, 1'b1);
		send_line(3, 1, 1'b1);
		send_line(64, 16, 1'b1);
		send_line(200, 48, 1'b1);

		cur_phase = 3;
		send_line(scan_doubler_pkg::max_line_pixels, 100, 1'b1);

		cur_phase = 4;
		send_line(scan_doubler_pkg::max_line_pixels + 76, 96, 1'b1);

		cur_phase = 5;
		send_line(6, 2, 1'b1);
		end_stream();
		stream_done = 1'b1;

		limit = 4 * scan_doubler_pkg::max_line_pixels;
		k = 0;
		while (!drain_checked && k < limit) begin
			@(negedge pixel_clk_in);
			k++;
		end
		if (!drain_checked) begin
			$display("playback did not go idle within %0d cycles after the last line", limit);
			timeout_count++;
		end

		$display("%0d errors, %0d pixels checked", error_count + timeout_count, pixel_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule
